// File: common/prosparsity_defines.svh
// Sizing macros for the product-sparsity front end
// One tile at most PS_ROWS rows deep, rows are PS_SPIKES spikes wide
// PS_NO_WIDTH must hold a popcount of 0 to PS_SPIKES
// PS_IDX_W must index PS_ROWS rows
`ifndef PROSPARSITY_DEFINES_SVH
`define PROSPARSITY_DEFINES_SVH

// Table depth and maximum rows per tile
`define PS_ROWS 16

// Spikes per row
`define PS_SPIKES 8

`define PS_NO_WIDTH 4
`define PS_IDX_W 4

// Idle cycles in collection before a tile is closed
`define PS_TIMEOUT_RST 64

`endif

// File: common/spike_pkg.sv
// Data types shared by the spike datapath
// Widths follow the sizing macros, so change them there only
`include "prosparsity_defines.svh"

package spike_pkg;

    // Row position inside a tile
    typedef logic [`PS_IDX_W-1:0] row_idx_t;

    // One binary spike row
    typedef logic [`PS_SPIKES-1:0] pattern_t;

    // Number of set spikes in a row
    typedef logic [`PS_NO_WIDTH-1:0] popcnt_t;

endpackage

// File: common/ctrl_pkg.sv
// Control encodings for the pruner, dispatcher and config block
// Opcode values are visible on the cfg_op port, keep them fixed

package ctrl_pkg;

    typedef enum logic [2:0] {
        DISP_IDLE     = 3'd0,
        DISP_COLLECT  = 3'd1,
        DISP_SORT     = 3'd2,
        DISP_DISPATCH = 3'd3,
        DISP_DONE     = 3'd4
    } disp_state_t;

    typedef enum logic [1:0] {
        PRUNE_IDLE   = 2'd0,
        PRUNE_SEARCH = 2'd1,
        PRUNE_OFFER  = 2'd2
    } prune_state_t;

    typedef enum logic [1:0] {
        CFG_NOP         = 2'd0,
        CFG_SET_TIMEOUT = 2'd1,
        CFG_CLEAR_TILES = 2'd2
    } cfg_op_t;

endpackage

// File: hw/pruner/pruner.sv
// Finds the prefix row of every incoming spike row within its tile
// One row in flight at a time, spike_ready is high only while idle
// Row i needs i search cycles, so descriptors come out i+1 cycles after accept
// Row indices restart only after spike_last
`timescale 1ns/1ps
`include "prosparsity_defines.svh"

module pruner
    import spike_pkg::*;
    import ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         spike_valid,
    input  pattern_t     spike_row,
    input  logic         spike_last,
    input  logic         row_info_ready,
    output logic         spike_ready,
    output logic         row_info_valid,
    output row_idx_t     row_idx,
    output row_idx_t     row_prefix_id,
    output pattern_t     row_pattern,
    output popcnt_t      row_popcnt,
    output logic         row_last
);

    prune_state_t state;
    prune_state_t next_state;

    // Patterns and popcounts of the rows seen so far in this tile
    pattern_t mem_pat [`PS_ROWS];
    popcnt_t  mem_pc  [`PS_ROWS];

    row_idx_t next_idx;
    row_idx_t scan_idx;
    row_idx_t cur_idx;
    pattern_t cur_pattern;
    popcnt_t  cur_popcnt;
    logic     cur_last;
    row_idx_t best_id;
    popcnt_t  best_pc;
    logic     accept;
    logic     hit;

    function automatic popcnt_t count_ones(input pattern_t p);
        popcnt_t n;
        n = '0;
        for (int b = 0; b < `PS_SPIKES; b++) begin
            n = n + popcnt_t'(p[b]);
        end
        return n;
    endfunction

    assign spike_ready = (state == PRUNE_IDLE);
    assign accept      = spike_valid && spike_ready;

    // Non-empty subset of the current row that beats the best so far
    // Strict compare keeps the lowest index on equal popcounts
    assign hit = (mem_pat[scan_idx] != '0) &&
                 ((mem_pat[scan_idx] & ~cur_pattern) == '0) &&
                 (mem_pc[scan_idx] > best_pc);

    always_comb begin
        next_state = state;
        case (state)
            PRUNE_IDLE: begin
                if (accept) begin
                    next_state = (next_idx == '0) ? PRUNE_OFFER : PRUNE_SEARCH;
                end
            end
            PRUNE_SEARCH: begin
                if (scan_idx == cur_idx - row_idx_t'(1)) begin
                    next_state = PRUNE_OFFER;
                end
            end
            PRUNE_OFFER: begin
                if (row_info_ready) begin
                    next_state = PRUNE_IDLE;
                end
            end
            default: next_state = PRUNE_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= PRUNE_IDLE;
            next_idx <= '0;
        end else begin
            state <= next_state;
            if (state == PRUNE_OFFER && row_info_ready) begin
                next_idx <= cur_last ? '0 : next_idx + row_idx_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            mem_pat[next_idx] <= spike_row;
            mem_pc[next_idx]  <= count_ones(spike_row);
            cur_idx           <= next_idx;
            cur_pattern       <= spike_row;
            cur_popcnt        <= count_ones(spike_row);
            cur_last          <= spike_last;
            scan_idx          <= '0;
            best_id           <= next_idx;
            best_pc           <= '0;
        end else if (state == PRUNE_SEARCH) begin
            if (hit) begin
                best_id <= scan_idx;
                best_pc <= mem_pc[scan_idx];
            end
            scan_idx <= scan_idx + row_idx_t'(1);
        end
    end

    assign row_info_valid = (state == PRUNE_OFFER);
    assign row_idx        = cur_idx;
    assign row_prefix_id  = best_id;
    assign row_pattern    = cur_pattern;
    assign row_popcnt     = cur_popcnt;
    assign row_last       = cur_last;

    // Descriptor must hold while the dispatcher stalls
    a_offer_hold: assert property (@(posedge clk) disable iff (!rst_n)
        row_info_valid && !row_info_ready |=> row_info_valid &&
        $stable(row_idx) && $stable(row_prefix_id) && $stable(row_pattern) &&
        $stable(row_popcnt) && $stable(row_last));

endmodule

// File: hw/dispatcher/dispatcher.sv
// Collects row descriptors, sorts them and issues one task per row
// Sort key is popcount, then row index, so a prefix always issues first
// Only one tile in flight, descriptors are refused outside collection
// The sort takes one cycle per collected row
`timescale 1ns/1ps
`include "prosparsity_defines.svh"

module dispatcher
    import spike_pkg::*;
    import ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        row_info_valid,
    input  row_idx_t    row_idx,
    input  row_idx_t    row_prefix_id,
    input  pattern_t    row_pattern,
    input  popcnt_t     row_popcnt,
    input  logic        row_last,
    input  logic        proc_ready,
    input  logic [15:0] timeout_limit,
    output logic        row_info_ready,
    output logic        task_valid,
    output row_idx_t    task_row_id,
    output row_idx_t    task_prefix_id,
    output pattern_t    task_pattern,
    output logic        tile_done
);

    disp_state_t state;
    disp_state_t next_state;

    // Product sparsity table, indexed by row
    row_idx_t pst_prefix  [`PS_ROWS];
    pattern_t pst_pattern [`PS_ROWS];

    // Sort array, filled in collection order
    row_idx_t sort_row [`PS_ROWS];
    popcnt_t  sort_pc  [`PS_ROWS];

    logic [`PS_IDX_W:0] collect_count;
    logic [`PS_IDX_W:0] last_pos;
    logic [15:0]        idle_cnt;
    row_idx_t           sort_pos;
    row_idx_t           disp_pos;
    logic               accept;

    row_idx_t min_idx;
    popcnt_t  min_pc;
    row_idx_t min_row;

    assign row_info_ready = (state == DISP_IDLE) || (state == DISP_COLLECT);
    assign accept         = row_info_valid && row_info_ready;
    assign last_pos       = collect_count - 1'b1;

    // Smallest (popcount, row) over the unsorted tail
    always_comb begin
        min_idx = sort_pos;
        min_pc  = sort_pc[sort_pos];
        min_row = sort_row[sort_pos];
        for (int k = 0; k < `PS_ROWS; k++) begin
            if (k > int'(sort_pos) && k < int'(collect_count)) begin
                if (sort_pc[k] < min_pc ||
                    (sort_pc[k] == min_pc && sort_row[k] < min_row)) begin
                    min_idx = row_idx_t'(k);
                    min_pc  = sort_pc[k];
                    min_row = sort_row[k];
                end
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            DISP_IDLE, DISP_COLLECT: begin
                if (accept && (row_last || collect_count == `PS_ROWS - 1)) begin
                    next_state = DISP_SORT;
                end else if (accept) begin
                    next_state = DISP_COLLECT;
                end else if (state == DISP_COLLECT && idle_cnt >= timeout_limit) begin
                    next_state = DISP_SORT;
                end
            end
            DISP_SORT: begin
                if ({1'b0, sort_pos} == last_pos) begin
                    next_state = DISP_DISPATCH;
                end
            end
            DISP_DISPATCH: begin
                if (proc_ready && {1'b0, disp_pos} == last_pos) begin
                    next_state = DISP_DONE;
                end
            end
            default: next_state = DISP_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= DISP_IDLE;
            collect_count <= '0;
            idle_cnt      <= '0;
            sort_pos      <= '0;
            disp_pos      <= '0;
        end else begin
            state <= next_state;
            case (state)
                DISP_IDLE, DISP_COLLECT: begin
                    if (accept) begin
                        collect_count <= collect_count + 1'b1;
                        idle_cnt      <= '0;
                    end else if (state == DISP_COLLECT) begin
                        idle_cnt <= idle_cnt + 16'd1;
                    end
                end
                DISP_SORT: begin
                    sort_pos <= (next_state == DISP_DISPATCH) ? '0 : sort_pos + row_idx_t'(1);
                end
                DISP_DISPATCH: begin
                    if (proc_ready) begin
                        disp_pos <= (next_state == DISP_DONE) ? '0 : disp_pos + row_idx_t'(1);
                    end
                end
                default: begin
                    collect_count <= '0;
                    idle_cnt      <= '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pst_prefix[row_idx]                        <= row_prefix_id;
            pst_pattern[row_idx]                       <= row_pattern;
            sort_row[collect_count[`PS_IDX_W-1:0]]     <= row_idx;
            sort_pc[collect_count[`PS_IDX_W-1:0]]      <= row_popcnt;
        end else if (state == DISP_SORT) begin
            // Swap the minimum into place, harmless when it is already there
            sort_pc[min_idx]   <= sort_pc[sort_pos];
            sort_row[min_idx]  <= sort_row[sort_pos];
            sort_pc[sort_pos]  <= min_pc;
            sort_row[sort_pos] <= min_row;
        end
    end

    assign task_valid     = (state == DISP_DISPATCH) && proc_ready;
    assign task_row_id    = sort_row[disp_pos];
    assign task_prefix_id = pst_prefix[sort_row[disp_pos]];
    assign task_pattern   = pst_pattern[sort_row[disp_pos]];
    assign tile_done      = (state == DISP_DONE);

    a_task_in_dispatch: assert property (@(posedge clk) disable iff (!rst_n)
        task_valid |-> state == DISP_DISPATCH && {1'b0, disp_pos} < collect_count);

    a_collect_bound: assert property (@(posedge clk) disable iff (!rst_n)
        collect_count <= `PS_ROWS);

endmodule

// File: hw/dispatcher/dispatch_cfg.sv
// Holds the collection timeout and counts finished tiles
// The tile counter wraps at 16 bits
// A clear in the same cycle as tile_done leaves a count of one
`timescale 1ns/1ps
`include "prosparsity_defines.svh"

module dispatch_cfg
    import ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cfg_write,
    input  cfg_op_t     cfg_op,
    input  logic [15:0] cfg_data,
    input  logic        tile_done,
    output logic [15:0] timeout_limit,
    output logic [15:0] tile_count
);

    logic clear_tiles;

    assign clear_tiles = cfg_write && (cfg_op == CFG_CLEAR_TILES);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            timeout_limit <= 16'(`PS_TIMEOUT_RST);
        end else if (cfg_write && cfg_op == CFG_SET_TIMEOUT) begin
            timeout_limit <= cfg_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tile_count <= '0;
        end else if (clear_tiles) begin
            tile_count <= tile_done ? 16'd1 : 16'd0;
        end else if (tile_done) begin
            tile_count <= tile_count + 16'd1;
        end
    end

endmodule

// File: hw/prosparsity_top.sv
// Product-sparsity front end, pruner feeding the dispatcher
// Latency varies with tile contents, tile_done marks the end of a tile
// One tile is handled at a time
`timescale 1ns/1ps

module prosparsity_top
    import spike_pkg::*;
    import ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        spike_valid,
    input  pattern_t    spike_row,
    input  logic        spike_last,
    input  logic        proc_ready,
    input  logic        cfg_write,
    input  cfg_op_t     cfg_op,
    input  logic [15:0] cfg_data,
    output logic        spike_ready,
    output logic        task_valid,
    output row_idx_t    task_row_id,
    output row_idx_t    task_prefix_id,
    output pattern_t    task_pattern,
    output logic        tile_done,
    output logic [15:0] tile_count
);

    // Descriptor channel between pruner and dispatcher
    logic        row_info_valid;
    logic        row_info_ready;
    row_idx_t    row_idx;
    row_idx_t    row_prefix_id;
    pattern_t    row_pattern;
    popcnt_t     row_popcnt;
    logic        row_last;
    logic [15:0] timeout_limit;

    pruner u_pruner (
        .clk            (clk),
        .rst_n          (rst_n),
        .spike_valid    (spike_valid),
        .spike_row      (spike_row),
        .spike_last     (spike_last),
        .row_info_ready (row_info_ready),
        .spike_ready    (spike_ready),
        .row_info_valid (row_info_valid),
        .row_idx        (row_idx),
        .row_prefix_id  (row_prefix_id),
        .row_pattern    (row_pattern),
        .row_popcnt     (row_popcnt),
        .row_last       (row_last)
    );

    dispatcher u_dispatcher (
        .clk            (clk),
        .rst_n          (rst_n),
        .row_info_valid (row_info_valid),
        .row_idx        (row_idx),
        .row_prefix_id  (row_prefix_id),
        .row_pattern    (row_pattern),
        .row_popcnt     (row_popcnt),
        .row_last       (row_last),
        .proc_ready     (proc_ready),
        .timeout_limit  (timeout_limit),
        .row_info_ready (row_info_ready),
        .task_valid     (task_valid),
        .task_row_id    (task_row_id),
        .task_prefix_id (task_prefix_id),
        .task_pattern   (task_pattern),
        .tile_done      (tile_done)
    );

    dispatch_cfg u_dispatch_cfg (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_write     (cfg_write),
        .cfg_op        (cfg_op),
        .cfg_data      (cfg_data),
        .tile_done     (tile_done),
        .timeout_limit (timeout_limit),
        .tile_count    (tile_count)
    );

endmodule

// File: verif/tb_prosparsity_top.sv
// Testbench for the product-sparsity front end
// Tiles come from a table, part fixed and part LFSR filled, applied in order
// The timeout tile goes last, since row numbering carries on after a tile
// that closes without spike_last
// Stops at the first error
`timescale 1ns/1ps
`include "prosparsity_defines.svh"

module tb_prosparsity_top
    import spike_pkg::*;
    import ctrl_pkg::*;
();

    localparam int NUM_TILES = 6;
    // Fixed tile patterns, row 0 in the low byte
    localparam logic [63:0] FIX0 = 64'h13_11_0f_03_07_00_03_01;
    localparam logic [39:0] FIX1 = 40'h00_ff_c0_80_f0;
    localparam logic [31:0] FIX5 = 32'h24_3c_04_0c;

    logic        clk;
    logic        rst_n;
    logic        spike_valid;
    pattern_t    spike_row;
    logic        spike_last;
    logic        proc_ready;
    logic        cfg_write;
    cfg_op_t     cfg_op;
    logic [15:0] cfg_data;
    logic        spike_ready;
    logic        task_valid;
    row_idx_t    task_row_id;
    row_idx_t    task_prefix_id;
    pattern_t    task_pattern;
    logic        tile_done;
    logic [15:0] tile_count;

    // Stimulus table, a set mask bit stalls the processor on that cycle
    int          tile_rows [NUM_TILES];
    pattern_t    tile_pat  [NUM_TILES][`PS_ROWS];
    logic [31:0] tile_mask [NUM_TILES];
    logic        tile_last [NUM_TILES];

    // Expected task sequence of the current tile
    row_idx_t exp_row    [`PS_ROWS];
    row_idx_t exp_prefix [`PS_ROWS];
    pattern_t exp_pat    [`PS_ROWS];
    int       exp_count;

    logic [31:0] lfsr_state = 32'h1d1310db;
    int          cycle_cnt = 0;
    int          cycle_limit = 1000000;
    int          total_rows = 0;
    logic [15:0] since_clear;

    prosparsity_top DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .spike_valid    (spike_valid),
        .spike_row      (spike_row),
        .spike_last     (spike_last),
        .proc_ready     (proc_ready),
        .cfg_write      (cfg_write),
        .cfg_op         (cfg_op),
        .cfg_data       (cfg_data),
        .spike_ready    (spike_ready),
        .task_valid     (task_valid),
        .task_row_id    (task_row_id),
        .task_prefix_id (task_prefix_id),
        .task_pattern   (task_pattern),
        .tile_done      (tile_done),
        .tile_count     (tile_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            report_failure($sformatf("tile_done never arrived within %0d cycles", cycle_limit));
        end
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "run stopped on error");
    endtask

    task automatic check_row_idx(input string name, input row_idx_t got, input row_idx_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_pattern(input string name, input pattern_t got, input pattern_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic int ones_in(input pattern_t p);
        int c;
        c = 0;
        for (int b = 0; b < `PS_SPIKES; b++) begin
            c += p[b];
        end
        return c;
    endfunction

    task automatic build_table();
        logic [31:0] r;
        for (int t = 0; t < NUM_TILES; t++) begin
            tile_last[t] = (t != 5);
            if (t == 0 || t == 1 || t == 5) begin
                tile_rows[t] = (t == 0) ? 8 : (t == 1) ? 5 : 4;
                tile_mask[t] = (t == 0) ? 32'h0 : (t == 1) ? 32'h0003_36d8 : 32'h0000_0005;
                for (int i = 0; i < tile_rows[t]; i++) begin
                    tile_pat[t][i] = (t == 0) ? FIX0[8*i +: 8] :
                                     (t == 1) ? FIX1[8*i +: 8] : FIX5[8*i +: 8];
                end
            end else begin
                take_bits(4, r);
                tile_rows[t] = (t == 2) ? `PS_ROWS : int'(r[3:0]) + 1;
                // Every fourth cycle stays ready so dispatch always moves on
                take_bits(32, r);
                tile_mask[t] = r & 32'h7777_7777;
                for (int i = 0; i < tile_rows[t]; i++) begin
                    // Sparse rows give more subset matches
                    take_bits(16, r);
                    tile_pat[t][i] = r[15:8] & r[7:0];
                end
            end
            total_rows += tile_rows[t];
        end
        cycle_limit = 40 * total_rows + 200 * NUM_TILES;
    endtask

    // Prefix by subset rule, then stable order by popcount
    task automatic build_expected(input int t);
        int pc  [`PS_ROWS];
        int pre [`PS_ROWS];
        int ord [`PS_ROWS];
        int best;
        int j;
        for (int i = 0; i < tile_rows[t]; i++) begin
            pc[i]  = ones_in(tile_pat[t][i]);
            pre[i] = i;
            best   = 0;
            for (int m = 0; m < i; m++) begin
                if (tile_pat[t][m] != '0 && (tile_pat[t][m] & ~tile_pat[t][i]) == '0 &&
                    pc[m] > best) begin
                    pre[i] = m;
                    best   = pc[m];
                end
            end
        end
        for (int i = 0; i < tile_rows[t]; i++) begin
            j = i;
            while (j > 0 && pc[ord[j-1]] > pc[i]) begin
                ord[j] = ord[j-1];
                j--;
            end
            ord[j] = i;
        end
        for (int i = 0; i < tile_rows[t]; i++) begin
            exp_row[i]    = row_idx_t'(ord[i]);
            exp_prefix[i] = row_idx_t'(pre[ord[i]]);
            exp_pat[i]    = tile_pat[t][ord[i]];
        end
        exp_count = tile_rows[t];
    endtask

    task automatic send_row(input pattern_t p, input logic last);
        @(negedge clk);
        while (!spike_ready) @(negedge clk);
        @(posedge clk);
        spike_valid <= 1'b1;
        spike_row   <= p;
        spike_last  <= last;
        @(posedge clk);
        spike_valid <= 1'b0;
        spike_last  <= 1'b0;
    endtask

    task automatic write_cfg(input cfg_op_t op, input logic [15:0] d);
        @(posedge clk);
        cfg_write <= 1'b1;
        cfg_op    <= op;
        cfg_data  <= d;
        @(posedge clk);
        cfg_write <= 1'b0;
        cfg_op    <= CFG_NOP;
        cfg_data  <= '0;
        @(negedge clk);
    endtask

    // Applies the stall mask and checks each task until tile_done
    task automatic collect_tasks(input int t);
        logic [`PS_ROWS-1:0] seen;
        int n;
        int k;
        logic done;
        seen = '0;
        n    = 0;
        k    = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            proc_ready <= ~tile_mask[t][k % 32];
            @(negedge clk);
            if (task_valid) begin
                if (!proc_ready) begin
                    report_failure("task_valid was asserted while proc_ready was low");
                end
                if (n >= exp_count) begin
                    report_failure("the tile issued more tasks than it has rows");
                end
                check_row_idx("task_row_id", task_row_id, exp_row[n]);
                check_row_idx("task_prefix_id", task_prefix_id, exp_prefix[n]);
                check_pattern("task_pattern", task_pattern, exp_pat[n]);
                if (task_prefix_id != task_row_id && !seen[task_prefix_id]) begin
                    report_failure("a task was issued before the task of its prefix row");
                end
                seen[task_row_id] = 1'b1;
                n++;
            end
            if (tile_done) begin
                if (n != exp_count) begin
                    report_failure($sformatf("tile_done came after %0d of %0d tasks", n, exp_count));
                end
                // Under the reset timeout this tile could not close this early
                if (!tile_last[t] && k >= `PS_TIMEOUT_RST) begin
                    report_failure("the tile sent without spike_last was not closed by the short timeout");
                end
                done = 1'b1;
            end
            k++;
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        spike_valid = 1'b0;
        spike_row   = '0;
        spike_last  = 1'b0;
        proc_ready  = 1'b0;
        cfg_write   = 1'b0;
        cfg_op      = CFG_NOP;
        cfg_data    = '0;
        build_table();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (!spike_ready || task_valid || tile_done) begin
            report_failure("outputs did not take their reset values");
        end
        check_count("tile_count", tile_count, 16'd0);
        since_clear = '0;
        for (int t = 0; t < NUM_TILES; t++) begin
            if (t == 3) begin
                write_cfg(CFG_CLEAR_TILES, 16'd0);
                since_clear = '0;
                check_count("tile_count", tile_count, since_clear);
            end
            // Short limit so the tile closes without spike_last
            if (!tile_last[t]) begin
                write_cfg(CFG_SET_TIMEOUT, 16'd10);
            end
            build_expected(t);
            for (int i = 0; i < tile_rows[t]; i++) begin
                send_row(tile_pat[t][i], tile_last[t] && (i == tile_rows[t] - 1));
            end
            collect_tasks(t);
            since_clear = since_clear + 16'd1;
            @(posedge clk);
            proc_ready <= 1'b0;
            @(negedge clk);
            check_count("tile_count", tile_count, since_clear);
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: tb.f
+incdir+common
common/spike_pkg.sv
common/ctrl_pkg.sv
hw/pruner/pruner.sv
hw/dispatcher/dispatcher.sv
hw/dispatcher/dispatch_cfg.sv
hw/prosparsity_top.sv
verif/tb_prosparsity_top.sv

// File: Bender.yml
package:
  name: prosparsity

sources:
  - include_dirs:
      - common
    files:
      - common/spike_pkg.sv
      - common/ctrl_pkg.sv
      - hw/pruner/pruner.sv
      - hw/dispatcher/dispatcher.sv
      - hw/dispatcher/dispatch_cfg.sv
      - hw/prosparsity_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/tb_prosparsity_top.sv
